// ==== coh_l1.f ====
+incdir+src
src/coh_l1_pkg.sv
src/coh_credit_fifo.sv
src/coh_line_store.sv
src/coh_beat_counter.sv
src/coh_ctrl_fsm.sv
src/coh_l1_top.sv
test/tb_coh_l1.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the coh_l1 testbench with Verilator, run it, then search sim.log for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_coh_l1 -f coh_l1.f -o tb_coh_l1 \
    || { echo "build failed"; exit 1; }

./obj_dir/tb_coh_l1 > sim.log 2>&1
cat sim.log

grep -qx "RESULT: PASS" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== src/coh_beat_counter.sv ====
`timescale 1ns/1ps

module coh_beat_counter (
    input  logic CLK,
    input  logic reset,
    input  logic start, // New fill or writeback, back to the low half
    input  logic step,  // Current beat taken
    output logic beat,  // 0 low half, 1 high half
    output logic last   // Second step of the pair
);

    assign last = step && beat;

    // Wraps to the low half after the second step
    always_ff @(posedge CLK) begin
        if (reset)
            beat <= 1'b0;
        else if (start)
            beat <= 1'b0;
        else if (step)
            beat <= ~beat;
    end

endmodule

// ==== src/coh_credit_fifo.sv ====
`timescale 1ns/1ps
`include "coh_l1_cfg.svh"

module coh_credit_fifo import coh_l1_pkg::*; #(
    parameter type payload_t = proc_req_t
) (
    input  logic     CLK,
    input  logic     reset,
    input  logic     push,      // Sender only pushes while it holds a credit
    input  payload_t push_data,
    input  logic     pop,
    output payload_t head,
    output logic     not_empty,
    output logic     credit     // One pulse per entry popped
);

    localparam int DEPTH = `COH_Q_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t                   mem [DEPTH];
    logic [PTR_W-1:0]           rd_ptr;
    logic [PTR_W-1:0]           wr_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;
    logic                       pop_ok;

    // Wrap at DEPTH, also for depths that are not a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign not_empty = (count != '0);
    assign pop_ok    = pop && not_empty; // Pop of an empty queue is ignored
    assign credit    = pop_ok;           // Same cycle as the pop
    assign head      = mem[rd_ptr];

    always_ff @(posedge CLK) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop_ok)
                rd_ptr <= next_ptr(rd_ptr);
            case ({push, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;       // Both or neither
            endcase
        end
    end

    // Entry storage
    always_ff @(posedge CLK) begin
        if (push)
            mem[wr_ptr] <= push_data;
    end

endmodule

// ==== src/coh_ctrl_fsm.sv ====
`timescale 1ns/1ps
`include "coh_l1_cfg.svh"

module coh_ctrl_fsm import coh_l1_pkg::*; (
    input  logic                  CLK,
    input  logic                  reset,
    input  proc_req_t             proc_head,
    input  logic                  proc_pending,
    output logic                  proc_pop,
    input  snoop_req_t            snoop_head,
    input  logic                  snoop_pending,
    output logic                  snoop_pop,
    output logic [`COH_IDX_W-1:0] index,
    input  logic [`COH_TAG_W-1:0] tag,
    input  mesi_t                 state,
    input  logic [63:0]           data,
    output logic                  wr,
    output logic [`COH_TAG_W-1:0] wr_tag,
    output mesi_t                 wr_state,
    output logic [63:0]           wr_data,
    output logic                  beat_start,
    output logic                  beat_step,
    input  logic                  beat,
    input  logic                  last,
    output logic                  bus_req_valid,
    output bus_req_t              bus_req,
    input  logic                  bus_gnt_valid,
    input  bus_gnt_t              bus_gnt,
    input  logic                  l2_fill_valid,
    input  l2_beat_t              l2_fill,
    output logic                  l2_wb_valid,
    output l2_beat_t              l2_wb,
    input  logic                  l2_wb_ready,
    output logic                  proc_resp_valid,
    output proc_resp_t            proc_resp,
    output logic                  snoop_resp_valid,
    output snoop_resp_t           snoop_resp
);

    typedef enum logic [2:0] {
        IDLE, LOOKUP, WRITEBACK, BUS_WAIT, FILL, RESPOND
    } ctrl_state_t;

    ctrl_state_t           cs;
    ctrl_state_t           ns;
    proc_req_t             req_q;    // Processor request in service
    snoop_req_t            snp_q;    // Snoop in service
    logic                  is_snoop;
    logic [63:0]           blk_q;    // Victim, then fill or upgrade block
    logic                  shared_q; // Grant shared flag
    logic                  miss_q;
    bus_op_t               op_q;
    logic [`COH_ADDR_W-1:0] cur_addr;
    logic [`COH_TAG_W-1:0] cur_tag;
    logic                  hit;
    logic [63:0]           merged;   // Fill block with the write word applied

    function automatic logic [31:0] pick_word(input logic [63:0] blk, input logic hi);
        return hi ? blk[63:32] : blk[31:0];
    endfunction

    function automatic logic [63:0] merge_word(input logic [63:0] blk, input logic hi,
                                               input logic [31:0] w);
        logic [63:0] r;
        r = blk;
        if (hi)
            r[63:32] = w;
        else
            r[31:0] = w;
        return r;
    endfunction

    assign cur_addr = is_snoop ? snp_q.addr : req_q.addr;
    assign cur_tag  = cur_addr[`COH_ADDR_W-1 -: `COH_TAG_W];
    assign index    = cur_addr[3 +: `COH_IDX_W];
    assign hit      = (state != MESI_I) && (tag == cur_tag);
    assign merged   = req_q.write ? merge_word(blk_q, req_q.addr[2], req_q.wdata) : blk_q;

    always_ff @(posedge CLK) begin
        if (reset) begin
            cs       <= IDLE;
            is_snoop <= 1'b0;
        end else begin
            cs <= ns;
            if (snoop_pop)
                is_snoop <= 1'b1;
            else if (proc_pop)
                is_snoop <= 1'b0;
        end
    end

    // Request and block registers
    always_ff @(posedge CLK) begin
        if (snoop_pop)
            snp_q <= snoop_head;
        if (proc_pop)
            req_q <= proc_head;
        if (cs == LOOKUP && !is_snoop) begin
            blk_q  <= data;   // Victim for writeback, or the line for an upgrade
            miss_q <= !hit;
            op_q   <= hit ? BUS_UPGR : (req_q.write ? BUS_RDX : BUS_RD);
        end
        if (cs == BUS_WAIT && bus_gnt_valid) begin
            shared_q <= bus_gnt.shared;
            if (bus_gnt.from_cache && op_q != BUS_UPGR)
                blk_q <= bus_gnt.data; // Cache-to-cache fill
        end
        if (cs == FILL && l2_fill_valid) begin
            if (l2_fill.high)
                blk_q[63:32] <= l2_fill.data;
            else
                blk_q[31:0] <= l2_fill.data;
        end
    end

    always_comb begin
        ns               = cs;
        proc_pop         = 1'b0;
        snoop_pop        = 1'b0;
        wr               = 1'b0;
        wr_tag           = cur_tag;
        wr_state         = state;
        wr_data          = data;
        beat_start       = 1'b0;
        beat_step        = 1'b0;
        bus_req_valid    = 1'b0;
        bus_req.op       = op_q;
        bus_req.addr     = {cur_addr[`COH_ADDR_W-1:3], 3'b000};
        l2_wb_valid      = 1'b0;
        l2_wb.data       = pick_word(blk_q, beat); // Low half first
        l2_wb.high       = beat;
        proc_resp_valid  = 1'b0;
        proc_resp.rdata  = req_q.write ? req_q.wdata : pick_word(data, req_q.addr[2]);
        proc_resp.state  = state;
        proc_resp.miss   = 1'b0;
        snoop_resp_valid = 1'b0;
        snoop_resp.hit   = hit;
        snoop_resp.dirty = hit && (state == MESI_M);
        snoop_resp.data  = hit ? data : 64'd0;
        case (cs)
            IDLE: begin
                if (snoop_pending) begin // Snoops go first
                    snoop_pop = 1'b1;
                    ns        = LOOKUP;
                end else if (proc_pending) begin
                    proc_pop = 1'b1;
                    ns       = LOOKUP;
                end
            end
            LOOKUP: begin
                if (is_snoop) begin
                    snoop_resp_valid = 1'b1;
                    wr               = hit;
                    wr_state         = (snp_q.op == BUS_RD) ? MESI_S : MESI_I;
                    ns               = IDLE;
                end else if (hit && (!req_q.write || state != MESI_S)) begin
                    proc_resp_valid = 1'b1; // Hit, no bus traffic
                    if (req_q.write) begin
                        wr              = 1'b1;
                        wr_state        = MESI_M;
                        wr_data         = merge_word(data, req_q.addr[2], req_q.wdata);
                        proc_resp.state = MESI_M;
                    end
                    ns = IDLE;
                end else if (!hit && state == MESI_M) begin
                    beat_start = 1'b1; // Dirty victim goes out first
                    ns         = WRITEBACK;
                end else begin
                    ns = BUS_WAIT;     // Clean miss or upgrade
                end
            end
            WRITEBACK: begin
                l2_wb_valid = 1'b1;
                if (l2_wb_ready) begin
                    beat_step = 1'b1;
                    if (last)
                        ns = BUS_WAIT;
                end
            end
            BUS_WAIT: begin
                bus_req_valid = 1'b1; // Held until granted
                if (bus_gnt_valid) begin
                    if (op_q == BUS_UPGR || bus_gnt.from_cache) begin
                        ns = RESPOND;
                    end else begin
                        beat_start = 1'b1;
                        ns         = FILL;
                    end
                end
            end
            FILL: begin
                if (l2_fill_valid) begin
                    beat_step = 1'b1;
                    if (last)
                        ns = RESPOND;
                end
            end
            RESPOND: begin
                wr               = 1'b1;
                wr_data          = merged;
                wr_state         = req_q.write ? MESI_M : (shared_q ? MESI_S : MESI_E);
                proc_resp_valid  = 1'b1;
                proc_resp.rdata  = pick_word(merged, req_q.addr[2]);
                proc_resp.state  = req_q.write ? MESI_M : (shared_q ? MESI_S : MESI_E);
                proc_resp.miss   = miss_q;
                ns               = IDLE;
            end
            default: ns = IDLE;
        endcase
    end

endmodule

// ==== src/coh_l1_cfg.svh ====
`ifndef COH_L1_CFG_SVH
`define COH_L1_CFG_SVH

// Cache geometry, any power of two
`define COH_LINES 4
`define COH_Q_DEPTH 2         // Entries per request queue, also the credits after reset
`define COH_ADDR_W 32         // Byte address width
`define COH_TIMEOUT_PER_OP 64 // Testbench cycles allowed per stim line

// Derived widths, 64-bit block so 3 offset bits
`define COH_IDX_W ($clog2(`COH_LINES))
`define COH_TAG_W (`COH_ADDR_W - 3 - `COH_IDX_W)

`endif

// ==== src/coh_l1_pkg.sv ====
`include "coh_l1_cfg.svh"

package coh_l1_pkg;

    // Line coherence state
    typedef enum logic [1:0] {
        MESI_I = 2'd0,
        MESI_S = 2'd1,
        MESI_E = 2'd2,
        MESI_M = 2'd3
    } mesi_t;

    typedef enum logic [1:0] {
        BUS_RD   = 2'd0, // Read, others may keep a copy
        BUS_RDX  = 2'd1, // Read for ownership
        BUS_UPGR = 2'd2  // Invalidate others, no data
    } bus_op_t;

    typedef struct packed {
        logic                   write;
        logic [`COH_ADDR_W-1:0] addr;  // Byte address, bit 2 picks the word
        logic [31:0]            wdata;
    } proc_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        mesi_t       state; // Line state after the operation
        logic        miss;
    } proc_resp_t;

    typedef struct packed {
        bus_op_t                op;
        logic [`COH_ADDR_W-1:0] addr; // Block aligned
    } bus_req_t;

    typedef struct packed {
        logic        shared;     // Another cache keeps a copy
        logic        from_cache; // Data below is valid, no L2 beats follow
        logic [63:0] data;
    } bus_gnt_t;

    typedef struct packed {
        bus_op_t                op;
        logic [`COH_ADDR_W-1:0] addr;
    } snoop_req_t;

    typedef struct packed {
        logic        hit;
        logic        dirty; // Data supplied from a modified line
        logic [63:0] data;
    } snoop_resp_t;

    typedef struct packed {
        logic [31:0] data;
        logic        high; // Upper half of the block
    } l2_beat_t;

endpackage

// ==== src/coh_l1_top.sv ====
`timescale 1ns/1ps
`include "coh_l1_cfg.svh"

module coh_l1_top import coh_l1_pkg::*; (
    input  logic        CLK,
    input  logic        reset,
    input  logic        proc_req_valid,
    input  proc_req_t   proc_req,
    output logic        proc_credit,
    output logic        proc_resp_valid,
    output proc_resp_t  proc_resp,
    input  logic        snoop_valid,
    input  snoop_req_t  snoop,
    output logic        snoop_credit,
    output logic        snoop_resp_valid,
    output snoop_resp_t snoop_resp,
    output logic        bus_req_valid,
    output bus_req_t    bus_req,
    input  logic        bus_gnt_valid,
    input  bus_gnt_t    bus_gnt,
    input  logic        l2_fill_valid,
    input  l2_beat_t    l2_fill,
    output logic        l2_wb_valid,
    output l2_beat_t    l2_wb,
    input  logic        l2_wb_ready
);

    proc_req_t             proc_head;
    logic                  proc_pending;
    logic                  proc_pop;
    snoop_req_t            snoop_head;
    logic                  snoop_pending;
    logic                  snoop_pop;
    logic [`COH_IDX_W-1:0] index;
    logic [`COH_TAG_W-1:0] tag;
    mesi_t                 state;
    logic [63:0]           data;
    logic                  wr;
    logic [`COH_TAG_W-1:0] wr_tag;
    mesi_t                 wr_state;
    logic [63:0]           wr_data;
    logic                  beat_start;
    logic                  beat_step;
    logic                  beat;
    logic                  last;

    // Processor request queue
    coh_credit_fifo #(.payload_t(proc_req_t)) u_proc_q (
        .CLK(CLK), .reset(reset),
        .push(proc_req_valid), .push_data(proc_req),
        .pop(proc_pop), .head(proc_head), .not_empty(proc_pending),
        .credit(proc_credit)
    );

    // Snoop queue, same credit scheme
    coh_credit_fifo #(.payload_t(snoop_req_t)) u_snoop_q (
        .CLK(CLK), .reset(reset),
        .push(snoop_valid), .push_data(snoop),
        .pop(snoop_pop), .head(snoop_head), .not_empty(snoop_pending),
        .credit(snoop_credit)
    );

    coh_line_store u_store (
        .CLK(CLK), .reset(reset), .index(index),
        .tag(tag), .state(state), .data(data),
        .wr(wr), .wr_tag(wr_tag), .wr_state(wr_state), .wr_data(wr_data)
    );

    // Shared by fill and writeback
    coh_beat_counter u_beats (
        .CLK(CLK), .reset(reset), .start(beat_start), .step(beat_step),
        .beat(beat), .last(last)
    );

    coh_ctrl_fsm u_ctrl (
        .CLK(CLK), .reset(reset),
        .proc_head(proc_head), .proc_pending(proc_pending), .proc_pop(proc_pop),
        .snoop_head(snoop_head), .snoop_pending(snoop_pending), .snoop_pop(snoop_pop),
        .index(index), .tag(tag), .state(state), .data(data),
        .wr(wr), .wr_tag(wr_tag), .wr_state(wr_state), .wr_data(wr_data),
        .beat_start(beat_start), .beat_step(beat_step), .beat(beat), .last(last),
        .bus_req_valid(bus_req_valid), .bus_req(bus_req),
        .bus_gnt_valid(bus_gnt_valid), .bus_gnt(bus_gnt),
        .l2_fill_valid(l2_fill_valid), .l2_fill(l2_fill),
        .l2_wb_valid(l2_wb_valid), .l2_wb(l2_wb), .l2_wb_ready(l2_wb_ready),
        .proc_resp_valid(proc_resp_valid), .proc_resp(proc_resp),
        .snoop_resp_valid(snoop_resp_valid), .snoop_resp(snoop_resp)
    );

endmodule

// ==== src/coh_line_store.sv ====
`timescale 1ns/1ps
`include "coh_l1_cfg.svh"

module coh_line_store import coh_l1_pkg::*; (
    input  logic                  CLK,
    input  logic                  reset,
    input  logic [`COH_IDX_W-1:0] index,    // Shared by lookup and write
    output logic [`COH_TAG_W-1:0] tag,
    output mesi_t                 state,
    output logic [63:0]           data,
    input  logic                  wr,
    input  logic [`COH_TAG_W-1:0] wr_tag,
    input  mesi_t                 wr_state,
    input  logic [63:0]           wr_data
);

    logic [`COH_TAG_W-1:0] tag_mem   [`COH_LINES];
    mesi_t                 state_mem [`COH_LINES];
    logic [63:0]           data_mem  [`COH_LINES];

    // Combinational lookup of the indexed line
    assign tag   = tag_mem[index];
    assign state = state_mem[index];
    assign data  = data_mem[index];

    // All lines start invalid
    always_ff @(posedge CLK) begin
        if (reset) begin
            for (int i = 0; i < `COH_LINES; i++)
                state_mem[i] <= MESI_I;
        end else if (wr) begin
            state_mem[index] <= wr_state;
        end
    end

    always_ff @(posedge CLK) begin
        if (wr) begin
            tag_mem[index]  <= wr_tag;
            data_mem[index] <= wr_data;
        end
    end

endmodule

// ==== test/coh_l1_stim.txt ====
# Columns: kind f1 f2 f3 in hex. preq write addr wdata, pres rdata state miss, breq op addr
# gnt shared from_cache data, fill and wb low high, snp op addr, sres hit dirty data, cred proc snoop
preq 0 00000104 00000000
breq 0 00000100 0
gnt  0 0 0000000000000000
fill a0a00000 a0a00004 0
pres a0a00004 2 1
preq 0 00000100 00000000
pres a0a00000 2 0
end  1 0 0
preq 0 0000010c 00000000
breq 0 00000108 0
gnt  1 1 b1b1000cb1b10008
pres b1b1000c 1 1
preq 1 00000108 c0de0008
breq 2 00000108 0
gnt  0 0 0000000000000000
pres c0de0008 3 0
end  2 0 0
preq 1 00000114 d00d0014
breq 1 00000110 0
gnt  0 0 0000000000000000
fill e0e00010 e0e00014 0
pres d00d0014 3 1
preq 0 00000114 00000000
pres d00d0014 3 0
end  3 0 0
snp  0 00000110 0
sres 1 1 d00d0014e0e00010
preq 0 00000110 00000000
pres e0e00010 1 0
snp  1 00000110 0
sres 1 0 d00d0014e0e00010
preq 0 00000110 00000000
breq 0 00000110 0
gnt  0 0 0000000000000000
fill f0f00010 f0f00014 0
pres f0f00010 2 1
snp  0 00000300 0
sres 0 0 0000000000000000
end  4 0 0
preq 1 00000100 55550100
pres 55550100 3 0
preq 0 00000204 00000000
wb   55550100 a0a00004 0
breq 0 00000200 0
gnt  0 0 0000000000000000
fill 77770200 77770204 0
pres 77770204 2 1
end  5 0 0
preq 0 0000011c 00000000
preq 0 00000108 00000000
preq 0 0000010c 00000000
snp  0 00000108 0
snp  0 00000300 0
cred 0 0 0
breq 0 00000118 0
gnt  0 0 0000000000000000
fill 99990118 9999011c 0
pres 9999011c 2 1
sres 1 1 b1b1000cc0de0008
sres 0 0 0000000000000000
pres c0de0008 1 0
pres b1b1000c 1 0
cred 2 2 0
end  6 0 0

// ==== test/tb_coh_l1.sv ====
`timescale 1ns/1ps
`include "coh_l1_cfg.svh"

module tb_coh_l1 import coh_l1_pkg::*; ();

    logic        CLK = 1'b0;
    logic        reset;
    logic        proc_req_valid;
    proc_req_t   proc_req;
    logic        proc_credit;
    logic        proc_resp_valid;
    proc_resp_t  proc_resp;
    logic        snoop_valid;
    snoop_req_t  snoop;
    logic        snoop_credit;
    logic        snoop_resp_valid;
    snoop_resp_t snoop_resp;
    logic        bus_req_valid;
    bus_req_t    bus_req;
    logic        bus_gnt_valid;
    bus_gnt_t    bus_gnt;
    logic        l2_fill_valid;
    l2_beat_t    l2_fill;
    logic        l2_wb_valid;
    l2_beat_t    l2_wb;
    logic        l2_wb_ready = 1'b0;

    // Stim lines, a kind plus three hex fields
    string       op_kind [$];
    logic [63:0] op_f1 [$];
    logic [63:0] op_f2 [$];
    logic [63:0] op_f3 [$];
    logic        open_ok;

    integer      seed = 32'h8c4fe979;
    logic [31:0] rnd;
    int          limit = 0;      // Watchdog limit in cycles
    int          cycles = 0;
    int          proc_sent = 0;
    int          proc_returned = 0;
    int          snoop_sent = 0;
    int          snoop_returned = 0;
    int          presp_seen = 0;
    int          presp_exp = 0;
    int          sresp_seen = 0;
    int          sresp_exp = 0;
    int          bus_seen = 0;   // New bus requests raised by the DUT
    int          bus_exp = 0;
    int          wb_seen = 0;
    int          wb_exp = 0;
    int          checks = 0;
    int          errors = 0;
    int          test_errors = 0;
    int          tests = 0;
    logic        bus_prev = 1'b0;

    coh_l1_top i_dut (.*);

    always #2 CLK = ~CLK;        // 4 ns period

    // Random write-back stalls from L2
    always @(posedge CLK) begin
        #1;
        rnd         = $random(seed);
        l2_wb_ready = rnd[0];
    end

    // Event counters, sampled mid cycle
    always @(negedge CLK) begin
        if (proc_credit)
            proc_returned++;
        if (snoop_credit)
            snoop_returned++;
        if (proc_resp_valid)
            presp_seen++;
        if (snoop_resp_valid)
            sresp_seen++;
        if (l2_wb_valid && l2_wb_ready)
            wb_seen++;
        if (bus_req_valid && !bus_prev)
            bus_seen++;          // Rising edge only, a request is held until granted
        bus_prev = bus_req_valid;
    end

    task automatic count_error();
        errors++;
        test_errors++;
    endtask

    task automatic check_proc_resp(input proc_resp_t got, input proc_resp_t exp);
        checks++;
        if (got !== exp) begin
            $display("error: proc_resp got %h expected %h", got, exp);
            count_error();
        end
    endtask

    task automatic check_snoop_resp(input snoop_resp_t got, input snoop_resp_t exp);
        checks++;
        if (got !== exp) begin
            $display("error: snoop_resp got %h expected %h", got, exp);
            count_error();
        end
    endtask

    task automatic check_bus_req(input bus_req_t got, input bus_req_t exp);
        checks++;
        if (got !== exp) begin
            $display("error: bus_req got %h expected %h", got, exp);
            count_error();
        end
    endtask

    task automatic check_wb_beat(input l2_beat_t got, input l2_beat_t exp);
        checks++;
        if (got !== exp) begin
            $display("error: l2_wb got %h expected %h", got, exp);
            count_error();
        end
    endtask

    task automatic check_credit_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            $display("error: %s count got %h expected %h", name, got, exp);
            count_error();
        end
    endtask

    task automatic load_stim();
        int          fd;
        int          n;
        string       text;
        string       k;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] c;
        fd      = $fopen("test/coh_l1_stim.txt", "r");
        open_ok = (fd != 0);
        if (open_ok) begin
            while (!$feof(fd)) begin
                text = "";
                n    = $fgets(text, fd);
                if (n > 0 && text.getc(0) != "#") begin // Skip column notes
                    if ($sscanf(text, "%s %h %h %h", k, a, b, c) == 4) begin
                        op_kind.push_back(k);
                        op_f1.push_back(a);
                        op_f2.push_back(b);
                        op_f3.push_back(c);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Inputs change 1 ns after the edge, pulses last one cycle
    task automatic next_cycle();
        @(posedge CLK);
        #1;
        proc_req_valid = 1'b0;
        snoop_valid    = 1'b0;
        bus_gnt_valid  = 1'b0;
        l2_fill_valid  = 1'b0;
    endtask

    task automatic send_proc(input proc_req_t req);
        while (`COH_Q_DEPTH - proc_sent + proc_returned == 0)
            next_cycle();        // No credit left
        proc_req       = req;
        proc_req_valid = 1'b1;
        proc_sent++;
    endtask

    task automatic send_snoop(input snoop_req_t req);
        while (`COH_Q_DEPTH - snoop_sent + snoop_returned == 0)
            next_cycle();
        snoop       = req;
        snoop_valid = 1'b1;
        snoop_sent++;
    endtask

    task automatic drive_fill(input logic [31:0] lo, input logic [31:0] hi);
        l2_fill.data  = lo;      // Low half first
        l2_fill.high  = 1'b0;
        l2_fill_valid = 1'b1;
        next_cycle();
        l2_fill.data  = hi;
        l2_fill.high  = 1'b1;
        l2_fill_valid = 1'b1;
    endtask

    task automatic take_writeback(input logic [31:0] lo, input logic [31:0] hi);
        l2_beat_t exp;
        int       n;
        n = 0;
        while (n < 2) begin
            @(negedge CLK);
            if (bus_req_valid) begin
                $display("bus request raised before the writeback finished");
                count_error();
            end
            if (l2_wb_valid && l2_wb_ready) begin
                exp.data = (n == 0) ? lo : hi;
                exp.high = (n == 1);
                check_wb_beat(l2_wb, exp);
                n++;
            end
        end
        wb_exp += 2;
    endtask

    task automatic finish_test(input logic [63:0] num);
        if (presp_seen != presp_exp || sresp_seen != sresp_exp) begin
            $display("test %0d saw %0d processor and %0d snoop responses, expected %0d and %0d",
                     num, presp_seen, sresp_seen, presp_exp, sresp_exp);
            count_error();
        end
        if (bus_seen != bus_exp || wb_seen != wb_exp) begin
            $display("test %0d saw %0d bus requests and %0d wb beats, expected %0d and %0d",
                     num, bus_seen, wb_seen, bus_exp, wb_exp);
            count_error();
        end
        if (test_errors == 0)
            $display("test %0d: passed", num);
        else
            $display("test %0d: failed with %0d errors", num, test_errors);
        tests++;
        test_errors = 0;
    endtask

    task automatic run_op(input string k, input logic [63:0] a, input logic [63:0] b,
                          input logic [63:0] c);
        proc_req_t   preq;
        proc_resp_t  pres;
        snoop_req_t  sreq;
        snoop_resp_t sres;
        bus_req_t    breq;
        if (k == "preq") begin
            preq.write = a[0];
            preq.addr  = b[`COH_ADDR_W-1:0];
            preq.wdata = c[31:0];
            send_proc(preq);
        end else if (k == "pres") begin
            pres.rdata = a[31:0];
            pres.state = mesi_t'(b[1:0]);
            pres.miss  = c[0];
            @(negedge CLK);
            while (!proc_resp_valid)
                @(negedge CLK);
            check_proc_resp(proc_resp, pres);
            presp_exp++;
        end else if (k == "snp") begin
            sreq.op   = bus_op_t'(a[1:0]);
            sreq.addr = b[`COH_ADDR_W-1:0];
            send_snoop(sreq);
        end else if (k == "sres") begin
            sres.hit   = a[0];
            sres.dirty = b[0];
            sres.data  = c;
            @(negedge CLK);
            while (!snoop_resp_valid)
                @(negedge CLK);
            check_snoop_resp(snoop_resp, sres);
            sresp_exp++;
        end else if (k == "breq") begin
            breq.op   = bus_op_t'(a[1:0]);
            breq.addr = b[`COH_ADDR_W-1:0];
            @(negedge CLK);
            while (!bus_req_valid)
                @(negedge CLK);
            check_bus_req(bus_req, breq);
            bus_exp++;
        end else if (k == "gnt") begin
            bus_gnt.shared     = a[0]; // Peer cache keeps a copy
            bus_gnt.from_cache = b[0];
            bus_gnt.data       = c;
            bus_gnt_valid      = 1'b1;
        end else if (k == "fill") begin
            drive_fill(a[31:0], b[31:0]);
        end else if (k == "wb") begin
            take_writeback(a[31:0], b[31:0]);
        end else if (k == "cred") begin
            repeat (4) next_cycle(); // Let any stray credit show up
            check_credit_count("proc_credit", `COH_Q_DEPTH - proc_sent + proc_returned,
                               int'(a[31:0]));
            check_credit_count("snoop_credit", `COH_Q_DEPTH - snoop_sent + snoop_returned,
                               int'(b[31:0]));
        end else if (k == "end") begin
            finish_test(a);
        end else begin
            $display("unknown operation %s in the stim file", k);
            count_error();
        end
    endtask

    // Watchdog sized from the stim length
    initial begin
        wait (limit > 0);
        while (cycles < limit) begin
            @(posedge CLK);
            cycles++;
        end
        $display("run timed out after %0d cycles", cycles);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        reset          = 1'b1;
        proc_req_valid = 1'b0;
        proc_req       = '0;
        snoop_valid    = 1'b0;
        snoop          = '0;
        bus_gnt_valid  = 1'b0;
        bus_gnt        = '0;
        l2_fill_valid  = 1'b0;
        l2_fill        = '0;
        load_stim();
        if (!open_ok) begin
            $display("could not open test/coh_l1_stim.txt");
            $display("RESULT: FAIL");
        end else begin
            limit = op_kind.size() * `COH_TIMEOUT_PER_OP;
            repeat (2) @(posedge CLK);
            #1;
            reset = 1'b0;
            for (int i = 0; i < op_kind.size(); i++) begin
                next_cycle();
                run_op(op_kind[i], op_f1[i], op_f2[i], op_f3[i]);
            end
            if (tests == 0) begin
                $display("no tests found in the stim file");
                count_error();
            end
            $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
            if (errors == 0)
                $display("RESULT: PASS");
            else
                $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
